// File: run_sim.sh
#!/usr/bin/env bash
# build and run the turbo_simd_unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f turbo_simd_unit.f --top-module tb_turbo_simd_unit \
    --Mdir obj_dir -o tb_turbo_simd_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_turbo_simd_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

// File: src/simd_cmd_fifo.sv
// ----------------------------------------------------------
// command FIFO: circular store with occupancy count
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module simd_cmd_fifo
    import simd_io_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      push_i,
    input  wire simd_cmd_t push_cmd_i,
    input  wire logic      pop_i,
    output simd_cmd_t      head_cmd_o,
    output logic           full_o,
    output logic           empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    simd_cmd_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // ----------------------------------------------------------
    // pointers and count
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                // wrap by hand, depth need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_cmd_i;
        end
    end

    assign head_cmd_o = mem_q[rd_ptr_q];
    assign full_o     = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o    = (count_q == '0);

endmodule

`default_nettype wire

// File: src/simd_cmd_sink.sv
// ----------------------------------------------------------
// command sink: four-phase slave that pushes into the FIFO
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module simd_cmd_sink
    import simd_io_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      cmd_req_i,
    input  wire simd_cmd_t cmd_i,
    input  wire logic      fifo_full_i,
    output logic           cmd_ack_o,
    output logic           push_o,
    output simd_cmd_t      push_cmd_o
);

    typedef enum logic {
        SINK_IDLE  = 1'b0,
        SINK_ACKED = 1'b1
    } sink_state_e;

    sink_state_e state_q;
    sink_state_e state_d;

    // ----------------------------------------------------------
    // next state and push
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        push_o  = 1'b0;
        case (state_q)
            SINK_IDLE: begin
                // ack held back while the FIFO has no room
                if (cmd_req_i && !fifo_full_i) begin
                    push_o  = 1'b1;
                    state_d = SINK_ACKED;
                end
            end
            SINK_ACKED: begin
                // wait for req to drop before the next command
                if (!cmd_req_i) begin
                    state_d = SINK_IDLE;
                end
            end
            default: state_d = SINK_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SINK_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command is stable while req is high
    assign push_cmd_o = cmd_i;

    assign cmd_ack_o  = (state_q == SINK_ACKED);

endmodule

`default_nettype wire

// File: src/simd_exec.sv
// ----------------------------------------------------------
// execute stage: pops commands, registers results and
// drives the four-phase response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module simd_exec
    import simd_lane_pkg::*;
    import simd_io_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire simd_cmd_t head_cmd_i,
    input  wire logic      fifo_empty_i,
    input  wire logic      rsp_ack_i,
    output logic           pop_o,
    output logic           rsp_req_o,
    output vec_t           rsp_data_o
);

    typedef enum logic [1:0] {
        EXEC_IDLE    = 2'd0,
        EXEC_WAIT_HI = 2'd1,
        EXEC_WAIT_LO = 2'd2
    } exec_state_e;

    exec_state_e state_q;
    vec_t        lane_result;
    vec_t        result_q;

    simd_lane_ops u_simd_lane_ops (
        .cmd_i    (head_cmd_i),
        .result_o (lane_result)
    );

    // take the head whenever idle
    assign pop_o = (state_q == EXEC_IDLE) && !fifo_empty_i;

    // ----------------------------------------------------------
    // response FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= EXEC_IDLE;
        end else begin
            case (state_q)
                EXEC_IDLE: begin
                    if (pop_o) begin
                        state_q <= EXEC_WAIT_HI;
                    end
                end
                EXEC_WAIT_HI: begin
                    if (rsp_ack_i) begin
                        state_q <= EXEC_WAIT_LO;
                    end
                end
                EXEC_WAIT_LO: begin
                    // back to idle, next pop one edge later
                    if (!rsp_ack_i) begin
                        state_q <= EXEC_IDLE;
                    end
                end
                default: state_q <= EXEC_IDLE;
            endcase
        end
    end

    // result held for the whole response
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            result_q <= lane_result;
        end
    end

    assign rsp_req_o  = (state_q == EXEC_WAIT_HI);
    assign rsp_data_o = result_q;

endmodule

`default_nettype wire

// File: src/simd_io_pkg.sv
// ----------------------------------------------------------
// command struct for the handshake and the command FIFO
// ----------------------------------------------------------
`default_nettype none

package simd_io_pkg;

    import simd_lane_pkg::*;

    // ----------------------------------------------------------
    // one command, 196 bits
    // ----------------------------------------------------------
    // op sits in the top bits, imm in the bottom 64
    typedef struct packed {
        simd_op_e op;
        // first operand vector
        vec_t     a;
        // second operand, also shuffle indices
        vec_t     b;
        // third operand, blend mask for OP_BLEND
        vec_t     imm;
    } simd_cmd_t;

    // handy for width checks in the top level
    localparam int CMD_W = $bits(simd_cmd_t);

endpackage

`default_nettype wire

// File: src/simd_lane_ops.sv
// ----------------------------------------------------------
// per-lane packed-byte arithmetic and byte shuffle network
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module simd_lane_ops
    import simd_lane_pkg::*;
    import simd_io_pkg::*;
(
    input  wire simd_cmd_t cmd_i,
    output vec_t           result_o
);

    // ----------------------------------------------------------
    // one slice per lane, all results wrap to 8 bits
    // ----------------------------------------------------------
    for (genvar i = 0; i < LANES; i++) begin : g_lane

        lane_t              a;
        lane_t              b;
        lane_t              imm;
        lane_t              r_max;
        lane_t              r_add;
        lane_t              r_sub;
        lane_t              r_divadd;
        lane_t              r_divsub;
        lane_t              r_sat;
        lane_t              r_sb_sat;
        lane_t              r_imm_sub;
        lane_t              r_maxpm;
        lane_t              r_accupp;
        lane_t              r_accupm;
        lane_t              r_blend;
        logic [LANE_W-1:0]  mag;
        logic [LANE_W-1:0]  mag_scaled;
        lane_t              r_scale;
        logic [IDX_W-1:0]   idx;
        lane_t              r_shuffle;
        lane_t              res;

        assign a   = cmd_i.a[i*LANE_W +: LANE_W];
        assign b   = cmd_i.b[i*LANE_W +: LANE_W];
        assign imm = cmd_i.imm[i*LANE_W +: LANE_W];

        // signed max, b wins ties
        assign r_max = (a <= b) ? b : a;

        assign r_add = a + b;
        assign r_sub = a - b;

        // halving ops shift in a zero, not the sign
        assign r_divadd = {1'b0, r_add[LANE_W-1:1]};
        assign r_divsub = {1'b0, r_sub[LANE_W-1:1]};

        // clamp to +-63 then subtract b
        assign r_sat = (a > SAT_LIMIT)  ? lane_t'(SAT_LIMIT)  :
                       (a < -SAT_LIMIT) ? lane_t'(-SAT_LIMIT) : a;
        assign r_sb_sat = r_sat - b;

        // max of (a+b) and (imm-b)
        assign r_imm_sub = imm - b;
        assign r_maxpm   = (r_add < r_imm_sub) ? r_imm_sub : r_add;

        assign r_accupp = r_add + imm;
        assign r_accupm = r_add - imm;

        // imm acts as a bit mask, set bits take a
        assign r_blend = (a & imm) | (b & ~imm);

        // scale by 3/4 on the magnitude, -128 stays 0x80
        assign mag        = a[LANE_W-1] ? LANE_W'(-a) : a;
        assign mag_scaled = mag - (mag >> 2);
        assign r_scale    = (a[LANE_W-1] ? lane_t'(-mag_scaled) : lane_t'(mag_scaled)) + b;

        // ------------------------------------------------------
        // shuffle: pick a byte of A by index
        // ------------------------------------------------------
        assign idx = b[IDX_W-1:0];

        always_comb begin
            r_shuffle = '0;
            // indices of 8 and up give zero
            if (b != SHFL_ZERO_KEY && idx < LANES) begin
                r_shuffle = cmd_i.a[idx*LANE_W +: LANE_W];
            end
        end

        // result select
        always_comb begin
            case (cmd_i.op)
                OP_MAX:     res = r_max;
                OP_ADDS:    res = r_add;
                OP_SUBS:    res = r_sub;
                OP_ACCUPP:  res = r_accupp;
                OP_ACCUPM:  res = r_accupm;
                OP_SHUFFLE: res = r_shuffle;
                OP_DIV_ADD: res = r_divadd;
                OP_DIV_SUB: res = r_divsub;
                OP_SB_SAT:  res = r_sb_sat;
                OP_MAXPM:   res = r_maxpm;
                OP_BLEND:   res = r_blend;
                OP_SCALE:   res = r_scale;
                // undefined codes return zero
                default:    res = '0;
            endcase
        end

        assign result_o[i*LANE_W +: LANE_W] = res;

    end

endmodule

`default_nettype wire

// File: src/simd_lane_pkg.sv
// ----------------------------------------------------------
// lane geometry, lane and vector types, operation codes
// ----------------------------------------------------------
`default_nettype none

package simd_lane_pkg;

    // ----------------------------------------------------------
    // geometry
    // ----------------------------------------------------------
    localparam int LANE_W = 8;
    localparam int LANES  = 8;
    localparam int VEC_W  = LANE_W * LANES;

    // shuffle index bits taken from each b lane
    localparam int IDX_W  = 4;

    // ----------------------------------------------------------
    // lane and vector types
    // ----------------------------------------------------------
    typedef logic signed [LANE_W-1:0] lane_t;
    typedef logic        [VEC_W-1:0]  vec_t;

    // ----------------------------------------------------------
    // operation codes, 12 to 15 unused
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        OP_MAX     = 4'd0,
        OP_ADDS    = 4'd1,
        OP_SUBS    = 4'd2,
        OP_ACCUPP  = 4'd3,
        OP_ACCUPM  = 4'd4,
        OP_SHUFFLE = 4'd5,
        OP_DIV_ADD = 4'd6,
        OP_DIV_SUB = 4'd7,
        OP_SB_SAT  = 4'd8,
        OP_MAXPM   = 4'd9,
        OP_BLEND   = 4'd10,
        OP_SCALE   = 4'd11
    } simd_op_e;

    // clamp bound of sb_sat
    localparam int SAT_LIMIT = 63;

    // b lane value that zeroes a shuffle lane
    localparam logic [LANE_W-1:0] SHFL_ZERO_KEY = 8'h01;

endpackage

`default_nettype wire

// File: src/turbo_simd_unit.sv
// ----------------------------------------------------------
// packed-byte SIMD unit: command sink, FIFO, execute stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module turbo_simd_unit
    import simd_lane_pkg::*;
    import simd_io_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      cmd_req_i,
    input  wire simd_cmd_t cmd_i,
    input  wire logic      rsp_ack_i,
    output logic           cmd_ack_o,
    output logic           rsp_req_o,
    output vec_t           rsp_data_o
);

    logic      push;
    simd_cmd_t push_cmd;
    logic      fifo_full;
    logic      fifo_empty;
    simd_cmd_t head_cmd;
    logic      pop;

    simd_cmd_sink u_simd_cmd_sink (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_req_i   (cmd_req_i),
        .cmd_i       (cmd_i),
        .fifo_full_i (fifo_full),
        .cmd_ack_o   (cmd_ack_o),
        .push_o      (push),
        .push_cmd_o  (push_cmd)
    );

    simd_cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_simd_cmd_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (push),
        .push_cmd_i (push_cmd),
        .pop_i      (pop),
        .head_cmd_o (head_cmd),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty)
    );

    simd_exec u_simd_exec (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .head_cmd_i   (head_cmd),
        .fifo_empty_i (fifo_empty),
        .rsp_ack_i    (rsp_ack_i),
        .pop_o        (pop),
        .rsp_req_o    (rsp_req_o),
        .rsp_data_o   (rsp_data_o)
    );

endmodule

`default_nettype wire

// File: test/tb_turbo_simd_unit.sv
// ----------------------------------------------------------
// testbench with clock, reset, directed table, reference model,
// LFSR stimulus, back-pressure run and watchdog
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_turbo_simd_unit
    import simd_lane_pkg::*;
    import simd_io_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_RAND   = 40;
    localparam int CMD_CYCLES = 20;
    // cycles to wait for an ack before calling the FIFO full
    localparam int BP_WAIT    = 10;

    // shared operands with lanes 7..0 from left to right
    localparam vec_t VA      = 64'h807F_3FC1_0040_BF05;
    localparam vec_t VB      = 64'h0101_FF00_80C0_7F03;
    localparam vec_t VI      = 64'h7F80_013F_C100_FF02;
    localparam vec_t SB_MASK = 64'h010F_0800_1706_8102;
    localparam vec_t SB_REV  = 64'h0011_0203_0405_0607;

    typedef struct packed {
        simd_cmd_t cmd;
        vec_t      expected;
    } test_vec_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_req;
    simd_cmd_t   cmd;
    logic        rsp_ack;
    logic        cmd_ack;
    logic        rsp_req;
    vec_t        rsp_data;
    logic [31:0] lfsr_q = 32'h3a2936a7;
    test_vec_t   table_q[$];
    string       names_q[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    turbo_simd_unit #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_turbo_simd_unit (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .cmd_req_i  (cmd_req),
        .cmd_i      (cmd),
        .rsp_ack_i  (rsp_ack),
        .cmd_ack_o  (cmd_ack),
        .rsp_req_o  (rsp_req),
        .rsp_data_o (rsp_data)
    );

    // ----------------------------------------------------------
    // reference model and random source
    // ----------------------------------------------------------
    function automatic int wrap8(input int x);
        byte w;
        w = x[7:0];
        return int'(w);
    endfunction

    function automatic vec_t ref_model(input simd_cmd_t c);
        vec_t r;
        int   a;
        int   b;
        int   imm;
        int   s;
        int   t;
        int   v;
        int   idx;
        r = '0;
        for (int i = 0; i < LANES; i++) begin
            a   = int'(signed'(c.a[i*LANE_W +: LANE_W]));
            b   = int'(signed'(c.b[i*LANE_W +: LANE_W]));
            imm = int'(signed'(c.imm[i*LANE_W +: LANE_W]));
            case (c.op)
                OP_MAX:     v = (a > b) ? a : b;
                OP_ADDS:    v = a + b;
                OP_SUBS:    v = a - b;
                OP_ACCUPP:  v = a + b + imm;
                OP_ACCUPM:  v = a + b - imm;
                OP_DIV_ADD: v = ((a + b) & 255) >> 1;
                OP_DIV_SUB: v = ((a - b) & 255) >> 1;
                OP_SB_SAT:  v = ((a > SAT_LIMIT) ? SAT_LIMIT :
                                 (a < -SAT_LIMIT) ? -SAT_LIMIT : a) - b;
                OP_MAXPM: begin
                    s = wrap8(a + b);
                    t = wrap8(imm - b);
                    v = (s > t) ? s : t;
                end
                OP_BLEND:   v = (a & imm) | (b & ~imm);
                OP_SCALE: begin
                    s = (a < 0) ? -a : a;
                    s = s - (s >> 2);
                    v = ((a < 0) ? -s : s) + b;
                end
                OP_SHUFFLE: begin
                    idx = int'(c.b[i*LANE_W +: IDX_W]);
                    if (c.b[i*LANE_W +: LANE_W] == SHFL_ZERO_KEY || idx >= LANES) begin
                        v = 0;
                    end else begin
                        v = int'(c.a[idx*LANE_W +: LANE_W]);
                    end
                end
                default:    v = 0;
            endcase
            r[i*LANE_W +: LANE_W] = v[7:0];
        end
        return r;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic vec_t rand_bits(input int n);
        vec_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[VEC_W-2:0], lfsr_step()};
        end
        return r;
    endfunction

    // LFSR operands around a given opcode
    function automatic simd_cmd_t rand_cmd(input logic [3:0] op);
        simd_cmd_t c;
        c.op  = simd_op_e'(op);
        c.a   = rand_bits(VEC_W);
        c.b   = rand_bits(VEC_W);
        c.imm = rand_bits(VEC_W);
        return c;
    endfunction

    // ----------------------------------------------------------
    // checker and handshake tasks
    // ----------------------------------------------------------
    task automatic check_value(input string name, input vec_t expected, input vec_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic add_entry(input string name, input logic [3:0] op, input vec_t a,
                             input vec_t b, input vec_t imm, input vec_t expected);
        test_vec_t e;
        e.cmd.op   = simd_op_e'(op);
        e.cmd.a    = a;
        e.cmd.b    = b;
        e.cmd.imm  = imm;
        e.expected = expected;
        table_q.push_back(e);
        names_q.push_back(name);
    endtask

    task automatic build_table();
        add_entry("max_edges",    OP_MAX,     VA, VB, VI, 64'h017F_3F00_0040_7F05);
        add_entry("adds_wrap",    OP_ADDS,    VA, VB, VI, 64'h8180_3EC1_8000_3E08);
        add_entry("subs_wrap",    OP_SUBS,    VA, VB, VI, 64'h7F7E_40C1_8080_4002);
        add_entry("div_add",      OP_DIV_ADD, VA, VB, VI, 64'h4040_1F60_4000_1F04);
        add_entry("div_sub",      OP_DIV_SUB, VA, VB, VI, 64'h3F3F_2060_4040_2001);
        add_entry("sb_sat",       OP_SB_SAT,  VA, VB, VI, 64'hC03E_40C1_807F_4202);
        add_entry("maxpm",        OP_MAXPM,   VA, VB, VI, 64'h7E7F_3E3F_4140_3E08);
        add_entry("accupp",       OP_ACCUPP,  VA, VB, VI, 64'h0000_3F00_4100_3D0A);
        add_entry("accupm",       OP_ACCUPM,  VA, VB, VI, 64'h0200_3D82_BF00_3F06);
        add_entry("blend",        OP_BLEND,   VA, VB, VI, 64'h0001_FF01_00C0_BF01);
        add_entry("scale",        OP_SCALE,   VA, VB, VI, 64'hA161_2FD0_80F0_4E07);
        // masked lanes, index 8 and 15, mixed picks
        add_entry("shuffle_mask", OP_SHUFFLE, VA, SB_MASK, VI, 64'h0000_0005_807F_BF40);
        add_entry("shuffle_rev",  OP_SHUFFLE, VA, SB_REV,  VI, 64'h05BF_4000_C13F_7F80);
        for (int k = 12; k < 16; k++) begin
            add_entry("undefined_op", 4'(k), VA, VB, VI, '0);
        end
    endtask

    task automatic start_cmd(input simd_cmd_t c);
        @(negedge clk);
        cmd     = c;
        cmd_req = 1'b1;
    endtask

    task automatic wait_cmd_ack(input logic level);
        @(negedge clk);
        while (cmd_ack !== level) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_ack_bounded(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < BP_WAIT) begin
            @(negedge clk);
            seen = cmd_ack;
            n++;
        end
    endtask

    task automatic end_cmd();
        cmd_req = 1'b0;
        wait_cmd_ack(1'b0);
    endtask

    task automatic recv_rsp(output vec_t data);
        @(negedge clk);
        while (rsp_req !== 1'b1) begin
            @(negedge clk);
        end
        data    = rsp_data;
        rsp_ack = 1'b1;
        @(negedge clk);
        while (rsp_req !== 1'b0) begin
            @(negedge clk);
        end
        rsp_ack = 1'b0;
    endtask

    task automatic run_cmd(input string name, input simd_cmd_t c, input vec_t expected);
        vec_t got;
        start_cmd(c);
        wait_cmd_ack(1'b1);
        end_cmd();
        recv_rsp(got);
        check_value(name, expected, got);
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin : main
        simd_cmd_t c;
        vec_t      got;
        vec_t      exp_q[$];
        int        accepted;
        bit        seen;
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd     = '0;
        rsp_ack = 1'b0;
        build_table();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset_cmd_ack", '0, vec_t'(cmd_ack));
        check_value("reset_rsp_req", '0, vec_t'(rsp_req));

        for (int k = 0; k < table_q.size(); k++) begin
            check_value({names_q[k], "_model"}, table_q[k].expected, ref_model(table_q[k].cmd));
            run_cmd(names_q[k], table_q[k].cmd, table_q[k].expected);
        end

        // LFSR operands with the opcode stepping through all 16 codes
        for (int k = 0; k < NUM_RAND; k++) begin
            c = rand_cmd(4'(k));
            run_cmd("random", c, ref_model(c));
        end

        // fill FIFO and exec stage with rsp_ack held low
        accepted = 0;
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            c = rand_cmd(4'(k));
            exp_q.push_back(ref_model(c));
            start_cmd(c);
            wait_ack_bounded(seen);
            if (!seen) begin
                break;
            end
            end_cmd();
            accepted++;
        end
        check_value("bp_accepted", vec_t'(FIFO_DEPTH + 1), vec_t'(accepted));
        recv_rsp(got);
        check_value("bp_result", exp_q.pop_front(), got);
        // refused command goes in once a slot frees
        wait_cmd_ack(1'b1);
        end_cmd();
        while (exp_q.size() > 0) begin
            recv_rsp(got);
            check_value("bp_result", exp_q.pop_front(), got);
        end

        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = (table_q.size() + NUM_RAND + FIFO_DEPTH + 8) * CMD_CYCLES * CLK_PERIOD;
        #(limit);
        $display("watchdog expired before all tests finished");
        $display("FAIL: see errors above");
        $fatal(1, "simulation timeout");
    end

endmodule

`default_nettype wire

// File: test/turbo_simd_props.sv
// ----------------------------------------------------------
// handshake assertions, bound into turbo_simd_unit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module turbo_simd_props
    import simd_lane_pkg::*;
(
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic cmd_req_i,
    input wire logic cmd_ack_i,
    input wire logic rsp_req_i,
    input wire logic rsp_ack_i,
    input wire vec_t rsp_data_i
);

    // ack only rises in answer to a request
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !cmd_ack_i && !cmd_req_i |=> !cmd_ack_i)
        else $error("cmd_ack_o rose without cmd_req_i");

    // response data held while req is up
    a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_req_i |=> !rsp_req_i || $stable(rsp_data_i))
        else $error("rsp_data_o changed while rsp_req_o was high");

    a_req_waits_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_req_i && !rsp_ack_i |=> rsp_req_i)
        else $error("rsp_req_o fell before rsp_ack_i was seen high");

endmodule

bind turbo_simd_unit turbo_simd_props u_turbo_simd_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_req_i  (cmd_req_i),
    .cmd_ack_i  (cmd_ack_o),
    .rsp_req_i  (rsp_req_o),
    .rsp_ack_i  (rsp_ack_i),
    .rsp_data_i (rsp_data_o)
);

`default_nettype wire

// File: turbo_simd_unit.f
src/simd_lane_pkg.sv
src/simd_io_pkg.sv
src/simd_cmd_sink.sv
src/simd_cmd_fifo.sv
src/simd_lane_ops.sv
src/simd_exec.sv
src/turbo_simd_unit.sv
test/turbo_simd_props.sv
test/tb_turbo_simd_unit.sv
